// ==== Bender.yml ====
package:
  name: slim_copper

sources:
  - hdl/copper_pkg.sv
  - hdl/copper_acc.sv
  - hdl/copper_fetch.sv
  - hdl/copper_beam_watch.sv
  - hdl/copper_ctrl.sv
  - hdl/copper_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/copper_tb.sv

// ==== dv/copper_tb_model.svh ====
/*
 * reference model of the copper for the testbench
 * runs the program in cop_mem from PC 0 and fills exp_q with the XR writes,
 * plus the value compare used by every check
 */
`ifndef COPPER_TB_MODEL_SVH
`define COPPER_TB_MODEL_SVH

// interpret cop_mem with RA and B clear, stop at a wait that never ends
function automatic void build_expected();
    copp_addr_t pc;
    word_t      w;
    word_t      im;
    word_t      ra;
    logic       b;
    exp_wr_t    cur;            // carries the last beam wait
    int         steps;
    logic       done;
    pc    = '0;
    ra    = '0;
    b     = 1'b0;
    cur   = '0;
    steps = 0;
    done  = 1'b0;
    exp_q.delete();
    while (!done && steps < 4096) begin
        w     = cop_mem[pc];
        pc    = pc + 1'b1;
        steps = steps + 1;
        case (w[13:12])
            2'b00: begin
                im = cop_mem[pc];
                pc = pc + 1'b1;
                if (w[15:14] == XR_CONFIG_REGION && w[COP_XREG]) begin
                    if (w[COP_XREG_SUB]) begin
                        b  = (ra < im);     // unsigned borrow
                        ra = ra - im;
                    end else begin
                        ra = im;
                    end
                end else begin
                    cur.wr = '{addr: w, data: im};
                    exp_q.push_back(cur);
                end
            end
            2'b01: pc = pc + 1'b1;          // SETM, second word skipped
            2'b10: begin
                cur.has_wait = 1'b1;
                cur.wait_v   = w[B_ARG];
                cur.wait_n   = hres_t'(w[B_ARG10:0]);
                // past the last line or pixel the beam never gets there
                done = w[B_ARG] ? (w[B_ARG10:0] >= TOTAL_HEIGHT) : (w[B_ARG10:0] >= TOTAL_WIDTH);
            end
            default: begin
                if (b == w[B_ARG]) pc = w[B_ARG10:0];   // BLT on borrow, BGE without
            end
        endcase
    end
endfunction

task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
    if (actual !== expected) begin
        value_errs++;
        $display("[ERROR] %0t ns: %s, got %h expected %h", $time, what, actual, expected);
    end
endtask

`endif

// ==== dv/copper_tb.sv ====
/*
 * testbench for the slim copper coprocessor
 * runs small programs from a copper memory model and checks every
 * acknowledged XR write against the reference model in the header
 */
`timescale 1ns/1ps

module copper_tb;
    import copper_pkg::*;

    localparam int N_PROGS     = 5;
    localparam int PROG_CYCLES = 4000;      // cycle budget per program
    localparam beam_pos_t START_POS = '{h: 11'd0, v: 11'd10};

    typedef struct packed {
        xr_write_t wr;
        logic      has_wait;                // write follows an HPOS/VPOS
        logic      wait_v;
        hres_t     wait_n;
    } exp_wr_t;

    typedef struct packed {
        xr_write_t wr;
        beam_pos_t beam;                    // beam in the ack cycle
    } got_wr_t;

    logic       clk = 1'b0;
    logic       cop_reset = 1'b1;
    beam_pos_t  beam_i = '0;
    logic       cop_xreg_wr_i = 1'b0;
    word_t      cop_xreg_data_i = '0;
    word_t      copmem_rd_data_i = '0;
    logic       xr_wr_ack_i = 1'b0;
    logic       copmem_rd_en_o;
    copp_addr_t copmem_rd_addr_o;
    logic       xr_wr_en_o;
    xr_write_t  xr_wr_o;

    word_t      cop_mem [1024];
    word_t      prog_q[$];
    exp_wr_t    exp_q[$];
    got_wr_t    got_q[$];
    integer     seed = 32'hf67b_e29f;
    int         value_errs = 0;
    int         other_errs = 0;
    int         ack_max = 0;                // longest ack delay in cycles
    int         ack_delay;
    logic       rd_pend = 1'b0;
    copp_addr_t rd_addr_q;
    logic       jump_req = 1'b0;
    beam_pos_t  jump_pos;
    logic       pend_valid = 1'b0;          // write seen, ack still out
    xr_write_t  pend_wr;

    `include "copper_tb_model.svh"

    copper_top dut0 (.*);

    always #20 clk = ~clk;

    // beam moves one pixel per clock unless a jump is asked for
    always @(posedge clk) begin
        #2;
        if (jump_req) begin
            beam_i   = jump_pos;
            jump_req = 1'b0;
        end else if (beam_i.h == hres_t'(TOTAL_WIDTH - 1)) begin
            beam_i.h = '0;
            beam_i.v = (beam_i.v == vres_t'(TOTAL_HEIGHT - 1)) ? '0 : beam_i.v + 1'b1;
        end else begin
            beam_i.h = beam_i.h + 1'b1;
        end
    end

    always @(posedge clk) begin
        #2;
        if (rd_pend) copmem_rd_data_i = cop_mem[rd_addr_q];    // one cycle after the strobe
        rd_pend   = copmem_rd_en_o;
        rd_addr_q = copmem_rd_addr_o;
    end

    always begin
        @(posedge clk);
        #2;
        xr_wr_ack_i = 1'b0;
        if (xr_wr_en_o) begin
            ack_delay = $unsigned($random(seed)) % (ack_max + 1);
            repeat (ack_delay) begin
                @(posedge clk);
                #2;
            end
            xr_wr_ack_i = 1'b1;
        end
    end

    // record acked writes, a pending write holds still until its ack
    always @(negedge clk) begin
        if (xr_wr_en_o) begin
            if (pend_valid) check_equal(xr_wr_o, pend_wr, "xr write moved before ack");
            if (xr_wr_ack_i) got_q.push_back('{wr: xr_wr_o, beam: beam_i});
            pend_valid = !xr_wr_ack_i;
            pend_wr    = xr_wr_o;
        end else if (pend_valid) begin
            $display("xr write pending at %0t ns was dropped without an ack", $time);
            other_errs++;
            pend_valid = 1'b0;
        end
    end

    initial begin
        #(N_PROGS * PROG_CYCLES * 40);
        $display("watchdog expired, the run did not finish in time");
        $display("** FAIL **");
        $finish;
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic set_enable(input logic on);
        tick();
        cop_xreg_wr_i   = 1'b1;
        cop_xreg_data_i = {on, 15'h0};      // bit 15 is enable
        tick();
        cop_xreg_wr_i   = 1'b0;
    endtask

    task automatic jump_beam(input beam_pos_t pos);
        @(negedge clk);
        jump_pos = pos;
        jump_req = 1'b1;
    endtask

    task automatic start_program();
        set_enable(1'b0);
        repeat (6) tick();                  // late ack dies out while held
        foreach (cop_mem[a]) cop_mem[a] = 16'h4400 | 16'(a);   // stray words show as writes
        foreach (prog_q[a]) cop_mem[a] = prog_q[a];
        build_expected();
        got_q.delete();
        jump_beam(START_POS);
        set_enable(1'b1);
    endtask

    task automatic wait_writes();
        int cnt;
        cnt = 0;
        while (got_q.size() < exp_q.size() && cnt < PROG_CYCLES) begin
            tick();
            cnt++;
        end
        if (got_q.size() < exp_q.size()) begin
            $display("timed out with %0d of %0d writes seen", got_q.size(), exp_q.size());
            other_errs++;
        end
    endtask

    task automatic finish_program(input string name);
        hres_t pos;
        repeat (100) tick();                // room for an extra write to show
        if (got_q.size() != exp_q.size()) begin
            $display("%s: %0d writes seen, %0d expected", name, got_q.size(), exp_q.size());
            other_errs++;
        end
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++) begin
            check_equal(got_q[i].wr, exp_q[i].wr, name);
            pos = exp_q[i].wait_v ? got_q[i].beam.v : got_q[i].beam.h;
            if (exp_q[i].has_wait) check_equal(pos >= exp_q[i].wait_n, 1, "write before beam wait");
        end
    endtask

    task automatic run_program(input string name);
        start_program();
        wait_writes();
        finish_program(name);
    endtask

    initial begin
        int n;
        repeat (16) tick();
        cop_reset = 1'b0;
        repeat (20) begin
            @(negedge clk);
            check_equal(xr_wr_en_o, 1'b0, "xr write while disabled");
            check_equal(copmem_rd_en_o, 1'b0, "memory read while disabled");
        end
        prog_q = '{16'h4000, 16'h1234, 16'h8005, 16'h5a5a, 16'h1000, 16'hffff,
                   16'hc3ff, 16'h0f0f, 16'h0100, 16'h8000, 16'h2bff};
        run_program("set list");
        ack_max = 3;                        // random ack delays from here on
        run_program("set list, slow ack");
        prog_q = '{16'h0800, 16'h0005, 16'h4010, 16'h00a5, 16'h0801, 16'h0001, 16'h3002,
                   16'h0800, 16'h0002, 16'h0801, 16'h0003, 16'h380e, 16'h4011, 16'hdead,
                   16'h4012, 16'h0042, 16'h2bff};
        run_program("ra loop");
        prog_q = '{16'h20c8, 16'h4020, 16'h0001, 16'h280c, 16'h4021, 16'h0002,
                   16'h22bc, 16'h4022, 16'h0003, 16'h2bff};
        run_program("beam waits");
        // BLT only taken when RA starts from zero
        prog_q = '{16'h0801, 16'h0001, 16'h3805, 16'h4030, 16'h0bad, 16'h4031, 16'h600d,
                   16'h2bff};
        start_program();
        wait_writes();
        n = exp_q.size();
        for (int i = 0; i < n; i++) exp_q.push_back(exp_q[i]);
        jump_beam('{h: hres_t'(RESTART_H), v: vres_t'(RESTART_V)});
        wait_writes();
        finish_program("frame restart");
        $display("closing: %0d value errors, %0d other errors", value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== hdl/copper_acc.sv ====
/*
 * copper accumulator RA and borrow flag B
 * written through the COP_RA and COP_RA_SUB pseudo registers
 * B is the unsigned borrow of the last subtract, read by BGE/BLT
 */
`timescale 1ns/1ps

module copper_acc (
    input  logic              clk,
    input  logic              cop_reset,
    input  logic              restart_i,
    input  logic              acc_wr_i,
    input  logic              acc_sub_i,
    input  copper_pkg::word_t acc_val_i,
    output logic              b_flag_o
);
    import copper_pkg::*;

    word_t       ra;
    logic [16:0] diff;      // borrow in bit 16

    assign diff = {1'b0, ra} - {1'b0, acc_val_i};

    always_ff @(posedge clk) begin
        if (cop_reset || restart_i) begin
            ra       <= '0;
            b_flag_o <= 1'b0;
        end else if (acc_wr_i) begin
            if (acc_sub_i) begin
                ra       <= diff[15:0];
                b_flag_o <= diff[16];   // set when RA < value
            end else begin
                ra       <= acc_val_i;  // plain load leaves B alone
            end
        end
    end

endmodule

// ==== hdl/copper_beam_watch.sv ====
/*
 * copper enable register, frame restart and beam position wait
 * restart is held while disabled and pulses once at the restart position
 * waiting drops a cycle after the selected beam count reaches the value
 */
`timescale 1ns/1ps

module copper_beam_watch (
    input  logic                  clk,
    input  logic                  cop_reset,
    input  copper_pkg::beam_pos_t beam_i,
    input  logic                  cop_xreg_wr_i,
    input  copper_pkg::word_t     cop_xreg_data_i,
    input  logic                  wait_start_i,
    input  logic                  wait_for_v_i,
    input  copper_pkg::hres_t     wait_val_i,
    output logic                  restart_o,
    output logic                  waiting_o
);
    import copper_pkg::*;

    logic  enable;
    logic  at_restart;      // beam sits just before frame start
    logic  reached;         // selected count >= wait value
    logic  wait_for_v;
    hres_t wait_val;

    assign at_restart = (beam_i.h == hres_t'(RESTART_H)) && (beam_i.v == vres_t'(RESTART_V));
    assign reached    = wait_for_v ? (beam_i.v >= vres_t'(wait_val)) : (beam_i.h >= wait_val);

    always_ff @(posedge clk) begin
        if (cop_reset) begin
            enable    <= 1'b0;
            restart_o <= 1'b1;
            waiting_o <= 1'b0;
        end else begin
            restart_o <= !enable || at_restart;
            if (cop_xreg_wr_i) enable <= cop_xreg_data_i[15];   // ctrl reg enable bit
            if (restart_o) waiting_o <= 1'b0;                   // restart drops any wait
            else if (wait_start_i) waiting_o <= 1'b1;
            else if (waiting_o && reached) waiting_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wait_start_i) begin
            wait_val   <= wait_val_i;
            wait_for_v <= wait_for_v_i;
        end
    end

endmodule

// ==== hdl/copper_ctrl.sv ====
/*
 * copper execution FSM
 * decodes each fetched word, routes SET data to the XR bus or to the
 * accumulator pseudo regs, starts beam waits and resolves BGE/BLT
 */
`timescale 1ns/1ps

module copper_ctrl (
    input  logic                   clk,
    input  logic                   cop_reset,
    input  logic                   restart_i,
    input  logic                   word_valid_i,
    input  copper_pkg::word_t      word_i,
    input  logic                   waiting_i,
    input  logic                   b_flag_i,
    input  logic                   xr_wr_ack_i,
    output logic                   fetch_req_o,
    output logic                   branch_o,
    output copper_pkg::copp_addr_t branch_target_o,
    output logic                   acc_wr_o,
    output logic                   acc_sub_o,
    output copper_pkg::word_t      acc_val_o,
    output logic                   wait_start_o,
    output logic                   wait_for_v_o,
    output copper_pkg::hres_t      wait_val_o,
    output logic                   xr_wr_en_o,
    output copper_pkg::xr_write_t  xr_wr_o
);
    import copper_pkg::*;

    copp_state_t  state;
    word_t        ir;           // first word of the executing instruction
    copp_opcode_t new_op;       // opcode of the word arriving now
    copp_opcode_t ir_op;
    logic         two_word;     // arriving word needs a second word
    logic         pseudo;       // ir targets a copper pseudo register

    assign new_op   = copp_opcode_t'(word_i[B_OPCODE +: 2]);
    assign ir_op    = copp_opcode_t'(ir[B_OPCODE +: 2]);
    assign two_word = !word_i[B_OPCODE+1];
    assign pseudo   = (ir[15:14] == XR_CONFIG_REGION) && ir[COP_XREG];

    // operands come straight off the arriving word
    assign branch_target_o = word_i[B_ARG10:0];
    assign wait_val_o      = hres_t'(word_i[B_ARG10:0]);
    assign wait_for_v_o    = word_i[B_ARG];
    assign acc_val_o       = word_i;                // immediate of SET
    assign acc_sub_o       = ir[COP_XREG_SUB];

    // one-cycle strobes to the units
    always_comb begin
        fetch_req_o  = 1'b0;
        branch_o     = 1'b0;
        acc_wr_o     = 1'b0;
        wait_start_o = 1'b0;
        case (state)
            ST_FETCH: fetch_req_o = !waiting_i;     // hold off while beam wait runs
            ST_DECODE: begin
                if (word_valid_i) begin
                    fetch_req_o  = two_word;        // second word read right away
                    wait_start_o = (new_op == OP_HVPOS);
                    // BGE takes on B clear, BLT on B set
                    branch_o     = (new_op == OP_BCC) && (b_flag_i == word_i[B_ARG]);
                end
            end
            ST_IMM: acc_wr_o = word_valid_i && (ir_op == OP_SET) && pseudo;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (cop_reset || restart_i) begin
            state      <= ST_FETCH;
            xr_wr_en_o <= 1'b0;
        end else begin
            case (state)
                ST_FETCH: begin
                    if (!waiting_i) state <= ST_DECODE;
                end
                ST_DECODE: begin
                    if (word_valid_i) state <= two_word ? ST_IMM : ST_FETCH;
                end
                ST_IMM: begin
                    if (word_valid_i) begin
                        if ((ir_op == OP_SET) && !pseudo) begin
                            xr_wr_en_o <= 1'b1;     // present write, held until ack
                            state      <= ST_HOLD;
                        end else begin
                            state      <= ST_FETCH; // pseudo reg write or SETM skip
                        end
                    end
                end
                ST_HOLD: begin
                    if (xr_wr_ack_i) begin
                        xr_wr_en_o <= 1'b0;
                        state      <= ST_FETCH;
                    end
                end
                default: state <= ST_FETCH;
            endcase
        end
    end

    // instruction and XR write payload
    always_ff @(posedge clk) begin
        if (state == ST_DECODE && word_valid_i) ir <= word_i;
        if (state == ST_IMM && word_valid_i) begin
            xr_wr_o.addr <= ir;     // SET word doubles as XR address
            xr_wr_o.data <= word_i;
        end
    end

    // pending write stays put until the bus takes it
    a_xr_wr_stable: assert property (@(posedge clk) disable iff (cop_reset || restart_i)
        (xr_wr_en_o && !xr_wr_ack_i) |=> (xr_wr_en_o && $stable(xr_wr_o)));

    // no memory read is issued while a write is pending
    a_no_fetch_in_write: assert property (@(posedge clk) disable iff (cop_reset)
        !(fetch_req_o && xr_wr_en_o));

endmodule

// ==== hdl/copper_fetch.sv ====
/*
 * copper program counter and memory read port
 * a fetch request reads the word at PC and bumps PC, a branch loads PC
 * the word comes back one cycle after the read, marked by word_valid_o
 */
`timescale 1ns/1ps

module copper_fetch (
    input  logic                   clk,
    input  logic                   cop_reset,
    input  logic                   restart_i,
    input  logic                   fetch_req_i,
    input  logic                   branch_i,
    input  copper_pkg::copp_addr_t branch_target_i,
    output logic                   copmem_rd_en_o,
    output copper_pkg::copp_addr_t copmem_rd_addr_o,
    input  copper_pkg::word_t      copmem_rd_data_i,
    output logic                   word_valid_o,
    output copper_pkg::word_t      word_o
);
    import copper_pkg::*;

    copp_addr_t pc;

    assign word_o = copmem_rd_data_i;   // memory has its own output register

    always_ff @(posedge clk) begin
        if (cop_reset || restart_i) begin
            pc             <= '0;       // program starts at word 0
            copmem_rd_en_o <= 1'b0;
            word_valid_o   <= 1'b0;
        end else begin
            copmem_rd_en_o <= fetch_req_i;      // one-cycle read pulse
            word_valid_o   <= copmem_rd_en_o;   // data lands a cycle later
            if (fetch_req_i) begin
                pc <= pc + 1'b1;
            end else if (branch_i) begin
                pc <= branch_target_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_req_i) copmem_rd_addr_o <= pc;
    end

    // controller never reads and branches in the same cycle
    a_branch_xor_fetch: assert property (@(posedge clk) disable iff (cop_reset)
        !(branch_i && fetch_req_i));

endmodule

// ==== hdl/copper_pkg.sv ====
/*
 * shared widths, types and constants for the slim copper coprocessor
 * every copper module imports this inside its body and uses scoped
 * names in its port list
 */
package copper_pkg;

    typedef logic [15:0] word_t;            // data, instruction or XR address word
    typedef logic [9:0]  copp_addr_t;       // copper memory word address
    typedef logic [10:0] hres_t;            // horizontal beam count
    typedef logic [10:0] vres_t;            // vertical beam count

    // current beam position from the video timing
    typedef struct packed {
        hres_t h;                           // pixel within the line
        vres_t v;                           // line within the frame
    } beam_pos_t;

    // one write on the XR register bus
    typedef struct packed {
        word_t addr;                        // region in [15:14], register offset below
        word_t data;
    } xr_write_t;

    // opcode field, instruction bits 13:12
    typedef enum logic [1:0] {
        OP_SET   = 2'b00,                   // SET xadr14,#im16 (two words)
        OP_SETM  = 2'b01,                   // no-op here, second word skipped
        OP_HVPOS = 2'b10,                   // HPOS/VPOS wait
        OP_BCC   = 2'b11                    // BGE/BLT
    } copp_opcode_t;

    // execution state
    typedef enum logic [1:0] {
        ST_FETCH  = 2'b00,                  // issue read at PC, stalls on a beam wait
        ST_DECODE = 2'b01,                  // first word arrives and is decoded
        ST_IMM    = 2'b10,                  // second word arrives
        ST_HOLD   = 2'b11                   // XR write pending until ack
    } copp_state_t;

    // instruction field positions
    localparam int B_OPCODE = 12;           // low bit of opcode, bit 13 clear means two words
    localparam int B_ARG    = 11;           // VPOS vs HPOS, BLT vs BGE
    localparam int B_ARG10  = 9;            // top bit of im10/cadr10

    // pseudo register decode
    localparam int COP_XREG     = 11;       // set in XR addr for copper internal regs
    localparam int COP_XREG_SUB = 0;        // 0 loads RA, 1 subtracts from RA

    localparam logic [1:0] XR_CONFIG_REGION = 2'b00;    // region that holds the pseudo regs

    // frame geometry
    localparam int TOTAL_WIDTH  = 800;
    localparam int TOTAL_HEIGHT = 525;

    // program restarts a few pixels before the frame wraps
    localparam int RESTART_H = TOTAL_WIDTH - 4;
    localparam int RESTART_V = TOTAL_HEIGHT - 1;

endpackage

// ==== hdl/copper_top.sv ====
/*
 * slim copper top level
 * connects the controller to its fetch, accumulator and beam watch units
 * plug into the video core next to copper memory and the XR bus
 */
`timescale 1ns/1ps

module copper_top (
    input  logic                   clk,
    input  logic                   cop_reset,
    input  copper_pkg::beam_pos_t  beam_i,
    input  logic                   cop_xreg_wr_i,
    input  copper_pkg::word_t      cop_xreg_data_i,
    output logic                   copmem_rd_en_o,
    output copper_pkg::copp_addr_t copmem_rd_addr_o,
    input  copper_pkg::word_t      copmem_rd_data_i,
    output logic                   xr_wr_en_o,
    output copper_pkg::xr_write_t  xr_wr_o,
    input  logic                   xr_wr_ack_i
);
    import copper_pkg::*;

    logic       restart;        // level, clears all units
    logic       fetch_req;
    logic       branch;
    copp_addr_t branch_target;
    logic       word_valid;     // word below is valid this cycle
    word_t      word;
    logic       acc_wr;
    logic       acc_sub;
    word_t      acc_val;
    logic       b_flag;
    logic       wait_start;
    logic       wait_for_v;
    hres_t      wait_val;
    logic       waiting;

    copper_ctrl ctrl0 (
        .clk, .cop_reset, .restart_i(restart), .word_valid_i(word_valid), .word_i(word),
        .waiting_i(waiting), .b_flag_i(b_flag), .xr_wr_ack_i, .fetch_req_o(fetch_req),
        .branch_o(branch), .branch_target_o(branch_target), .acc_wr_o(acc_wr),
        .acc_sub_o(acc_sub), .acc_val_o(acc_val), .wait_start_o(wait_start),
        .wait_for_v_o(wait_for_v), .wait_val_o(wait_val), .xr_wr_en_o, .xr_wr_o
    );

    copper_fetch fetch0 (
        .clk, .cop_reset, .restart_i(restart), .fetch_req_i(fetch_req), .branch_i(branch),
        .branch_target_i(branch_target), .copmem_rd_en_o, .copmem_rd_addr_o,
        .copmem_rd_data_i, .word_valid_o(word_valid), .word_o(word)
    );

    copper_acc acc0 (
        .clk, .cop_reset, .restart_i(restart), .acc_wr_i(acc_wr), .acc_sub_i(acc_sub),
        .acc_val_i(acc_val), .b_flag_o(b_flag)
    );

    copper_beam_watch beam0 (
        .clk, .cop_reset, .beam_i, .cop_xreg_wr_i, .cop_xreg_data_i,
        .wait_start_i(wait_start), .wait_for_v_i(wait_for_v), .wait_val_i(wait_val),
        .restart_o(restart), .waiting_o(waiting)
    );

endmodule

// ==== verilog.f ====
+incdir+dv
hdl/copper_pkg.sv
hdl/copper_acc.sv
hdl/copper_fetch.sv
hdl/copper_beam_watch.sv
hdl/copper_ctrl.sv
hdl/copper_top.sv
dv/copper_tb.sv
